// File: sources.f
+incdir+hw
hw/ulaPkg.sv
hw/pixelBus.sv
hw/rasterTiming.sv
hw/videoFetch.sv
hw/stdColour.sv
hw/plusPalette.sv
hw/cpuPorts.sv
hw/videoOutput.sv
hw/ulaTop.sv
bench/ulaBench.sv

// File: Makefile
# Verilator build and run of the ULA video core testbench

VERILATOR ?= verilator
TOP       ?= ulaBench
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard hw/*.svh)
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/ulaBench.sv
`timescale 1ns/10ps
`include "ula_config.svh"

module ulaBench;

   localparam int frameClocks = `LINE_CLOCKS * `FRAME_LINES;
   // Longest wait, two full frames
   localparam int waitLimit = 2 * frameClocks;

   typedef enum logic [2:0] {
      opWrite,
      opRead,
      opPins,
      opProbe,
      opSync,
      opPalette
   } opT;

   // What a probed pixel should show
   typedef enum logic [1:0] {
      srcBlank,
      srcBorder,
      srcPaper
   } srcT;

   typedef struct packed {
      opT          kind;
      srcT         src;
      logic [15:0] addr;
      logic [7:0]  data;
      logic [8:0]  line;
      logic [8:0]  col;
   } stepT;

   logic        clk7 = 1'b0;
   logic        rst_n;
   logic [15:0] a;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   logic [7:0]  din;
   logic [7:0]  dout;
   logic        ear;
   logic [4:0]  kbd;
   logic        mic;
   logic        spk;
   logic [13:0] va;
   logic [7:0]  vramData = 8'h00;
   logic [2:0]  r;
   logic [2:0]  g;
   logic [2:0]  b;
   logic        hsync;
   logic        vsync;
   logic        int_n;

   logic [7:0]  vram [16384];
   stepT        steps [$];

   // Register mirrors, border starts red
   logic [2:0]  borderModel = 3'd2;
   logic [6:0]  palRegModel = 7'd0;
   logic        plusModel = 1'b0;
   logic [7:0]  paletteModel [64];

   // Raster position and frame count
   int          benchHc;
   int          benchVc;
   int          flashTicks = 0;

   ulaTop UUT (
      .clk7(clk7), .rst_n(rst_n), .a(a), .iorq_n(iorq_n), .rd_n(rd_n),
      .wr_n(wr_n), .din(din), .dout(dout), .ear(ear), .kbd(kbd), .mic(mic),
      .spk(spk), .va(va), .vramData(vramData), .r(r), .g(g), .b(b),
      .hsync(hsync), .vsync(vsync), .int_n(int_n)
   );

   // 10 MHz bench clock
   always #50 clk7 = ~clk7;

   ////////////////////////////////////////////////////////////////////////////
   // Raster position and VRAM model
   ////////////////////////////////////////////////////////////////////////////

   // Position 0,0 in the first clock after reset
   always @(posedge clk7) begin
      if (!rst_n) begin
         benchHc <= 0;
         benchVc <= 0;
      end else begin
         // Flash counter steps at the vsync line start
         if (benchVc == `VSYNC_LINE && benchHc == 0)
            flashTicks <= flashTicks + 1;
         if (benchHc == `LINE_CLOCKS - 1) begin
            benchHc <= 0;
            benchVc <= (benchVc == `FRAME_LINES - 1) ? 0 : benchVc + 1;
         end else begin
            benchHc <= benchHc + 1;
         end
      end
   end

   // Data for the current address, after the edge
   always @(posedge clk7) begin
      #5;
      vramData = vram[va];
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   task automatic reportError(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
         reportError($sformatf("FAIL %s: got %02h, expected %02h", name, got, exp));
   endtask

   task automatic checkRgb(input string name, input ulaPkg::rgbT got, input ulaPkg::rgbT exp);
      if (got !== exp)
         reportError($sformatf("FAIL %s: got %03h, expected %03h", name, got, exp));
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      if (got !== exp)
         reportError($sformatf("FAIL %s: got %0h, expected %0h", name, got, exp));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Expected colours
   ////////////////////////////////////////////////////////////////////////////

   // Channel off 000, on 101, on and bright 111
   function automatic ulaPkg::rgbT stdRgb(input logic bright, input logic [2:0] grb);
      ulaPkg::rgbT c;
      logic [2:0]  onLevel;
      onLevel = bright ? 3'b111 : 3'b101;
      c.g = grb[2] ? onLevel : 3'b000;
      c.r = grb[1] ? onLevel : 3'b000;
      c.b = grb[0] ? onLevel : 3'b000;
      return c;
   endfunction

   // GGGRRRBB entry, blue widened with its top bit
   function automatic ulaPkg::rgbT plusRgb(input logic [7:0] entry);
      ulaPkg::rgbT c;
      c.g = entry[7:5];
      c.r = entry[4:2];
      c.b = {entry[1:0], entry[1]};
      return c;
   endfunction

   function automatic ulaPkg::rgbT paperExpect(input int line, input int col);
      int         bitmapAddr;
      int         attrAddr;
      int         bitIdx;
      logic [7:0] bitmap;
      logic [7:0] attr;
      logic       raw;
      logic       flashOn;
      // Thirds of 64 lines, then pixel row, then character row
      bitmapAddr = (line / 64) * 2048 + (line % 8) * 256 + ((line / 8) % 8) * 32 + col / 8;
      attrAddr   = 6144 + (line / 8) * 32 + col / 8;
      bitmap     = vram[bitmapAddr[13:0]];
      attr       = vram[attrAddr[13:0]];
      // Leftmost pixel is bit 7
      bitIdx     = 7 - (col % 8);
      raw        = bitmap[bitIdx[2:0]];
      flashOn    = ((flashTicks / 16) % 2) == 1;
      if (plusModel)
         return plusRgb(raw ? paletteModel[{attr[7:6], 1'b0, attr[2:0]}]
                            : paletteModel[{attr[7:6], 1'b1, attr[5:3]}]);
      return stdRgb(attr[6], (raw ^ (attr[7] & flashOn)) ? attr[2:0] : attr[5:3]);
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Bus cycles and waits
   ////////////////////////////////////////////////////////////////////////////

   task automatic ioWrite(input logic [15:0] addr, input logic [7:0] data);
      a      = addr;
      din    = data;
      iorq_n = 1'b0;
      wr_n   = 1'b0;
      @(posedge clk7);
      #5;
      iorq_n = 1'b1;
      wr_n   = 1'b1;
      // Mirror of the register effects
      if (!addr[0])
         borderModel = data[2:0];
      else if (addr == `PORT_PLUS_ADDR)
         palRegModel = data[6:0];
      else if (addr == `PORT_PLUS_DATA) begin
         if (palRegModel[6])
            plusModel = data[0];
         else
            paletteModel[palRegModel[5:0]] = data;
      end
   endtask

   // dout sampled mid-cycle
   task automatic ioRead(input logic [15:0] addr, input logic [7:0] exp);
      a      = addr;
      iorq_n = 1'b0;
      rd_n   = 1'b0;
      @(negedge clk7);
      checkByte($sformatf("dout port %04h", addr), dout, exp);
      @(posedge clk7);
      #5;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
   endtask

   // Skips two attribute groups so that recent writes reach the picture
   task automatic waitPosition(input int line, input int hc);
      int count;
      count = 0;
      while (count < 16 || benchVc != line || benchHc != hc) begin
         if (count == waitLimit)
            reportError($sformatf("timed out waiting for line %0d clock %0d", line, hc));
         @(posedge clk7);
         #5;
         count++;
      end
   endtask

   // Pixel x leaves the output register at hc x+9
   task automatic probePixel(input srcT src, input int line, input int col);
      ulaPkg::rgbT got;
      ulaPkg::rgbT exp;
      waitPosition(line, col + `FETCH_OFFSET + 1);
      got = {g, r, b};
      case (src)
         srcBorder:
            exp = plusModel ? plusRgb(paletteModel[{3'b001, borderModel}])
                            : stdRgb(1'b0, borderModel);
         srcPaper: exp = paperExpect(line, col);
         default:  exp = '0;
      endcase
      checkRgb($sformatf("rgb line %0d col %0d", line, col), got, exp);
   endtask

   task automatic checkSyncTiming;
      int count;
      count = 0;
      // Out of any vsync already running
      while (vsync !== 1'b1) begin
         if (count == waitLimit)
            reportError("vsync never went high");
         @(posedge clk7);
         #5;
         count++;
      end
      count = 0;
      while (vsync !== 1'b0) begin
         if (count == waitLimit)
            reportError("vsync never fell");
         @(posedge clk7);
         #5;
         count++;
      end
      if (benchVc != `VSYNC_LINE || benchHc != 0)
         reportError($sformatf("vsync fell at line %0d clock %0d instead of line %0d clock 0",
                               benchVc, benchHc, `VSYNC_LINE));
      checkBit("int_n", int_n, 1'b0);
      checkBit("hsync", hsync, 1'b1);
      count = 0;
      while (hsync !== 1'b0) begin
         if (count == `LINE_CLOCKS)
            reportError("hsync never fell on the vsync line");
         @(posedge clk7);
         #5;
         count++;
      end
      if (benchHc != `HSYNC_START)
         reportError($sformatf("hsync fell at clock %0d instead of %0d", benchHc, `HSYNC_START));
      checkBit("vsync", vsync, 1'b0);
      // Interrupt over by now
      checkBit("int_n", int_n, 1'b1);
   endtask

   // Entry value spread over the whole index
   task automatic loadPalette;
      for (int i = 0; i < 64; i++) begin
         ioWrite(`PORT_PLUS_ADDR, 8'(i));
         ioWrite(`PORT_PLUS_DATA, 8'(i * 37 + 11));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////////////////////////////////////////

   task automatic addStep(input opT kind, input srcT src, input logic [15:0] addr,
                          input logic [7:0] data, input int line, input int col);
      stepT s;
      s.kind = kind;
      s.src  = src;
      s.addr = addr;
      s.data = data;
      s.line = line[8:0];
      s.col  = col[8:0];
      steps.push_back(s);
   endtask

   task automatic buildTable;
      // Port FE, ear 1 and keys 15 throughout; pins data is spk, mic
      addStep(opWrite, srcBlank, 16'h00FE, 8'h18, 0, 0);
      addStep(opPins, srcBlank, 16'h0000, 8'h03, 0, 0);
      addStep(opRead, srcBlank, 16'h00FE, 8'hB5, 0, 0);
      addStep(opWrite, srcBlank, 16'hFEFE, 8'h0D, 0, 0);
      addStep(opPins, srcBlank, 16'h0000, 8'h01, 0, 0);
      addStep(opRead, srcBlank, 16'h7FFE, 8'hF5, 0, 0);
      addStep(opRead, srcBlank, 16'h1235, 8'hFF, 0, 0);
      // ULAplus register, one entry, config still off
      addStep(opWrite, srcBlank, 16'hBF3B, 8'h05, 0, 0);
      addStep(opRead, srcBlank, 16'hBF3B, 8'h05, 0, 0);
      addStep(opWrite, srcBlank, 16'hFF3B, 8'hA7, 0, 0);
      addStep(opRead, srcBlank, 16'hFF3B, 8'hA7, 0, 0);
      addStep(opWrite, srcBlank, 16'hBF3B, 8'h40, 0, 0);
      addStep(opRead, srcBlank, 16'hBF3B, 8'h40, 0, 0);
      addStep(opRead, srcBlank, 16'hFF3B, 8'h00, 0, 0);
      // Standard picture, magenta border
      addStep(opWrite, srcBlank, 16'h00FE, 8'h03, 0, 0);
      addStep(opPins, srcBlank, 16'h0000, 8'h00, 0, 0);
      addStep(opProbe, srcPaper, 16'h0000, 8'h00, 0, 0);
      addStep(opProbe, srcPaper, 16'h0000, 8'h00, 0, 7);
      addStep(opProbe, srcPaper, 16'h0000, 8'h00, 37, 123);
      addStep(opProbe, srcBorder, 16'h0000, 8'h00, 50, 300);
      addStep(opProbe, srcPaper, 16'h0000, 8'h00, 64, 64);
      addStep(opProbe, srcBlank, 16'h0000, 8'h00, 100, 340);
      addStep(opProbe, srcPaper, 16'h0000, 8'h00, 100, 255);
      addStep(opProbe, srcPaper, 16'h0000, 8'h00, 150, 17);
      addStep(opProbe, srcPaper, 16'h0000, 8'h00, 191, 200);
      addStep(opProbe, srcBorder, 16'h0000, 8'h00, 200, 100);
      addStep(opProbe, srcBlank, 16'h0000, 8'h00, 250, 50);
      addStep(opSync, srcBlank, 16'h0000, 8'h00, 0, 0);
      // ULAplus picture
      addStep(opPalette, srcBlank, 16'h0000, 8'h00, 0, 0);
      addStep(opWrite, srcBlank, 16'hBF3B, 8'h40, 0, 0);
      addStep(opWrite, srcBlank, 16'hFF3B, 8'h01, 0, 0);
      addStep(opRead, srcBlank, 16'hFF3B, 8'h01, 0, 0);
      addStep(opProbe, srcPaper, 16'h0000, 8'h00, 8, 8);
      addStep(opProbe, srcPaper, 16'h0000, 8'h00, 90, 131);
      addStep(opProbe, srcPaper, 16'h0000, 8'h00, 170, 250);
      addStep(opProbe, srcBorder, 16'h0000, 8'h00, 200, 100);
      addStep(opProbe, srcBlank, 16'h0000, 8'h00, 252, 10);
   endtask

   initial begin
      stepT step;
      a      = 16'h0000;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      wr_n   = 1'b1;
      din    = 8'h00;
      ear    = 1'b1;
      kbd    = 5'h15;
      rst_n  = 1'b0;
      void'($urandom(68488));
      for (int i = 0; i < 16384; i++)
         vram[i[13:0]] = 8'($urandom());
      repeat (8) @(posedge clk7);
      #5;
      rst_n = 1'b1;
      buildTable();
      foreach (steps[i]) begin
         step = steps[i];
         case (step.kind)
            opWrite: ioWrite(step.addr, step.data);
            opRead:  ioRead(step.addr, step.data);
            opPins: begin
               checkBit("mic", mic, step.data[0]);
               checkBit("spk", spk, step.data[1]);
            end
            opProbe:   probePixel(step.src, int'(step.line), int'(step.col));
            opSync:    checkSyncTiming();
            opPalette: loadPalette();
            default:   reportError("unknown table operation");
         endcase
      end
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// File: hw/ulaTop.sv
`timescale 1ns/10ps

module ulaTop (
   input  logic        clk7,
   input  logic        rst_n,
   input  logic [15:0] a,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic [7:0]  din,
   output logic [7:0]  dout,
   input  logic        ear,
   input  logic [4:0]  kbd,
   output logic        mic,
   output logic        spk,
   output logic [13:0] va,
   input  logic [7:0]  vramData,
   output logic [2:0]  r,
   output logic [2:0]  g,
   output logic [2:0]  b,
   output logic        hsync,
   output logic        vsync,
   output logic        int_n
);

   ulaPkg::rasterPosT hc;
   ulaPkg::rasterPosT vc;
   ulaPkg::fetchStepT fetchStep;
   logic              videoEnable;
   logic              serializerLoad;
   logic              frameTick;
   logic              blank;
   logic [2:0]        border;
   logic              paletteRegLoad;
   logic              paletteLoad;
   logic              configLoad;
   logic [6:0]        paletteReg;
   logic [7:0]        paletteEntry;
   logic              plusEnabled;
   ulaPkg::rgbT       stdRgb;
   ulaPkg::rgbT       plusRgb;

   pixelBus pixels ();

   rasterTiming uTiming (
      .clk7(clk7), .rst_n(rst_n), .hc(hc), .vc(vc), .fetchStep(fetchStep),
      .videoEnable(videoEnable), .serializerLoad(serializerLoad),
      .frameTick(frameTick), .blank(blank), .hsync(hsync), .vsync(vsync),
      .int_n(int_n)
   );

   videoFetch uFetch (
      .clk7(clk7), .hc(hc), .vc(vc), .fetchStep(fetchStep),
      .videoEnable(videoEnable), .serializerLoad(serializerLoad),
      .frameTick(frameTick), .border(border), .va(va), .vramData(vramData),
      .pix(pixels.fetch)
   );

   // Both colour paths run in parallel
   stdColour uStd (.pix(pixels.stdSide), .colour(stdRgb));

   plusPalette uPlus (
      .clk7(clk7), .rst_n(rst_n), .pix(pixels.plusSide), .din(din),
      .paletteRegLoad(paletteRegLoad), .paletteLoad(paletteLoad),
      .configLoad(configLoad), .paletteReg(paletteReg),
      .paletteEntry(paletteEntry), .plusEnabled(plusEnabled), .colour(plusRgb)
   );

   cpuPorts uPorts (
      .clk7(clk7), .rst_n(rst_n), .a(a), .iorq_n(iorq_n), .rd_n(rd_n),
      .wr_n(wr_n), .din(din), .dout(dout), .ear(ear), .kbd(kbd), .mic(mic),
      .spk(spk), .border(border), .paletteRegLoad(paletteRegLoad),
      .paletteLoad(paletteLoad), .configLoad(configLoad),
      .paletteReg(paletteReg), .paletteEntry(paletteEntry),
      .plusEnabled(plusEnabled)
   );

   videoOutput uOut (
      .clk7(clk7), .rst_n(rst_n), .stdColour(stdRgb), .plusColour(plusRgb),
      .plusEnabled(plusEnabled), .blank(blank), .r(r), .g(g), .b(b)
   );

endmodule

// File: hw/videoOutput.sv
`timescale 1ns/10ps

module videoOutput (
   input  logic        clk7,
   input  logic        rst_n,
   input  ulaPkg::rgbT stdColour,
   input  ulaPkg::rgbT plusColour,
   input  logic        plusEnabled,
   input  logic        blank,
   output logic [2:0]  r,
   output logic [2:0]  g,
   output logic [2:0]  b
);

   ulaPkg::rgbT rgbReg;

   // ULAplus wins when enabled, black in blanking
   always_ff @(posedge clk7) begin
      if (!rst_n)
         rgbReg <= '0;
      else if (blank)
         rgbReg <= '0;
      else if (plusEnabled)
         rgbReg <= plusColour;
      else
         rgbReg <= stdColour;
   end

   assign r = rgbReg.r;
   assign g = rgbReg.g;
   assign b = rgbReg.b;

endmodule

// File: hw/cpuPorts.sv
`timescale 1ns/10ps
`include "ula_config.svh"

module cpuPorts (
   input  logic        clk7,
   input  logic        rst_n,
   input  logic [15:0] a,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic [7:0]  din,
   output logic [7:0]  dout,
   input  logic        ear,
   input  logic [4:0]  kbd,
   output logic        mic,
   output logic        spk,
   output logic [2:0]  border,
   output logic        paletteRegLoad,
   output logic        paletteLoad,
   output logic        configLoad,
   input  logic [6:0]  paletteReg,
   input  logic [7:0]  paletteEntry,
   input  logic        plusEnabled
);

   ulaPkg::portSelT portSel;
   logic            ioWrite;
   logic            ioRead;

   assign ioWrite = !iorq_n && !wr_n;
   assign ioRead  = !iorq_n && !rd_n;

   // Any even port is the ULA
   always_comb begin
      portSel = ulaPkg::portNone;
      if (!iorq_n) begin
         if (!a[0])
            portSel = ulaPkg::portFe;
         else if (a == `PORT_PLUS_ADDR)
            portSel = ulaPkg::portPlusAddr;
         else if (a == `PORT_PLUS_DATA)
            portSel = ulaPkg::portPlusData;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Writes
   ////////////////////////////////////////////////////////////////////////////

   // Border powers up red
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         border <= 3'd2;
         mic    <= 1'b0;
         spk    <= 1'b0;
      end else if (ioWrite && portSel == ulaPkg::portFe) begin
         border <= din[2:0];
         mic    <= din[3];
         spk    <= din[4];
      end
   end

   // Register bit 6 selects config instead of an entry
   assign paletteRegLoad = ioWrite && (portSel == ulaPkg::portPlusAddr);
   assign paletteLoad    = ioWrite && (portSel == ulaPkg::portPlusData) && !paletteReg[6];
   assign configLoad     = ioWrite && (portSel == ulaPkg::portPlusData) && paletteReg[6];

   ////////////////////////////////////////////////////////////////////////////
   // Reads
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      dout = 8'hFF;
      if (ioRead) begin
         case (portSel)
            ulaPkg::portFe:       dout = {1'b1, ear ^ spk, 1'b1, kbd};
            ulaPkg::portPlusAddr: dout = {1'b0, paletteReg};
            ulaPkg::portPlusData: dout = paletteReg[6] ? {7'd0, plusEnabled} : paletteEntry;
            default:              dout = 8'hFF;
         endcase
      end
   end

   // Palette register, entry and config never load together
   assert property (@(posedge clk7) disable iff (!rst_n)
      $onehot0({paletteRegLoad, paletteLoad, configLoad}));

endmodule

// File: hw/plusPalette.sv
`timescale 1ns/10ps

module plusPalette (
   input  logic        clk7,
   input  logic        rst_n,
   pixelBus.plusSide   pix,
   input  logic [7:0]  din,
   input  logic        paletteRegLoad,
   input  logic        paletteLoad,
   input  logic        configLoad,
   output logic [6:0]  paletteReg,
   output logic [7:0]  paletteEntry,
   output logic        plusEnabled,
   output ulaPkg::rgbT colour
);

   // 64 entries, GGGRRRBB
   logic [7:0] palette [64];
   logic [5:0] paperIdx;
   logic [5:0] inkIdx;
   logic [7:0] paperLive;
   logic [7:0] inkLive;
   logic [7:0] paperHeld;
   logic [7:0] inkHeld;
   logic [7:0] entry;

   ////////////////////////////////////////////////////////////////////////////
   // CPU side registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         paletteReg  <= 7'd0;
         plusEnabled <= 1'b0;
      end else begin
         if (paletteRegLoad)
            paletteReg <= din[6:0];
         if (configLoad)
            plusEnabled <= din[0];
      end
   end

   always_ff @(posedge clk7) begin
      if (paletteLoad)
         palette[paletteReg[5:0]] <= din;
   end

   assign paletteEntry = palette[paletteReg[5:0]];

   ////////////////////////////////////////////////////////////////////////////
   // Pixel side
   ////////////////////////////////////////////////////////////////////////////

   // Paper in the upper half of each 16-entry group
   assign paperIdx  = {pix.attrByte[7:6], 1'b1, pix.attrByte[5:3]};
   assign inkIdx    = {pix.attrByte[7:6], 1'b0, pix.attrByte[2:0]};
   assign paperLive = palette[paperIdx];
   assign inkLive   = palette[inkIdx];

   // Entries held for the rest of the 8-pixel group
   always_ff @(posedge clk7) begin
      if (pix.attrLoad) begin
         paperHeld <= paperLive;
         inkHeld   <= inkLive;
      end
   end

   // First pixel of a group takes the fresh lookup
   always_comb begin
      if (pix.attrLoad)
         entry = pix.rawPixel ? inkLive : paperLive;
      else
         entry = pix.rawPixel ? inkHeld : paperHeld;
   end

   // Blue B1 B0 widens to B1 B0 B1
   assign colour = {entry, entry[1]};

endmodule

// File: hw/stdColour.sv
`timescale 1ns/10ps

module stdColour (
   pixelBus.stdSide    pix,
   output ulaPkg::rgbT colour
);

   logic       bright;
   logic [2:0] grb;

   // One channel level: off, half or full
   function automatic logic [2:0] level(input logic on, input logic hi);
      logic [2:0] lvl;
      lvl = 3'b000;
      if (on)
         lvl = hi ? 3'b111 : 3'b101;
      return lvl;
   endfunction

   assign bright = pix.attrByte[6];

   // Ink when the pixel is set, paper otherwise
   assign grb = pix.pixel ? pix.attrByte[2:0] : pix.attrByte[5:3];

   // Spectrum colour bits: 2 green, 1 red, 0 blue
   always_comb begin
      colour.g = level(grb[2], bright);
      colour.r = level(grb[1], bright);
      colour.b = level(grb[0], bright);
   end

endmodule

// File: hw/videoFetch.sv
`timescale 1ns/10ps

module videoFetch (
   input  logic              clk7,
   input  ulaPkg::rasterPosT hc,
   input  ulaPkg::rasterPosT vc,
   input  ulaPkg::fetchStepT fetchStep,
   input  logic              videoEnable,
   input  logic              serializerLoad,
   input  logic              frameTick,
   input  logic [2:0]        border,
   output ulaPkg::vramAddrT  va,
   input  logic [7:0]        vramData,
   pixelBus.fetch            pix
);

   logic [4:0] column;
   logic [7:0] bitmapData;
   logic [7:0] attrData;
   logic [7:0] shifter;
   logic [7:0] attrReg;
   logic       attrLoadReg;
   // Starts at phase 0 after configuration
   logic [4:0] flashCount = 5'd0;
   logic       flashPhase;

   ////////////////////////////////////////////////////////////////////////////
   // VRAM addressing
   ////////////////////////////////////////////////////////////////////////////

   // Column of the coming fetch
   always_ff @(posedge clk7) begin
      if (hc[2:0] == 3'd0)
         column <= hc[7:3];
   end

   // Bitmap lines interleaved by thirds, attributes after 6 KB
   always_comb begin
      if (fetchStep == ulaPkg::stepAttrAddr || fetchStep == ulaPkg::stepAttrLoad)
         va = {1'b0, 3'b110, vc[7:3], column};
      else
         va = {1'b0, vc[7:6], vc[2:0], vc[5:3], column};
   end

   always_ff @(posedge clk7) begin
      if (fetchStep == ulaPkg::stepBitmapLoad)
         bitmapData <= vramData;
      if (fetchStep == ulaPkg::stepAttrLoad)
         attrData <= vramData;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Serializer and attribute output
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (serializerLoad)
         shifter <= bitmapData;
      else
         shifter <= {shifter[6:0], 1'b0};
   end

   // Border goes in the paper bits outside the picture
   always_ff @(posedge clk7) begin
      if (hc[2:0] == 3'd7) begin
         if (serializerLoad)
            attrReg <= attrData;
         else
            attrReg <= {2'b00, border, 3'b000};
      end
      attrLoadReg <= (hc[2:0] == 3'd7);
   end

   // Flash toggles every 16 frames
   always_ff @(posedge clk7) begin
      if (frameTick)
         flashCount <= flashCount + 5'd1;
   end
   assign flashPhase = flashCount[4];

   assign pix.rawPixel = shifter[7] & videoEnable;
   assign pix.pixel    = pix.rawPixel ^ (attrReg[7] & flashPhase);
   assign pix.attrByte = attrReg;
   assign pix.attrLoad = attrLoadReg;

   // Bitmap fetched for a column is on screen six clocks later
   assert property (@(posedge clk7)
      (fetchStep == ulaPkg::stepBitmapLoad) |-> ##6 videoEnable);

endmodule

// File: hw/rasterTiming.sv
`timescale 1ns/10ps
`include "ula_config.svh"

module rasterTiming (
   input  logic              clk7,
   input  logic              rst_n,
   output ulaPkg::rasterPosT hc,
   output ulaPkg::rasterPosT vc,
   output ulaPkg::fetchStepT fetchStep,
   output logic              videoEnable,
   output logic              serializerLoad,
   output logic              frameTick,
   output logic              blank,
   output logic              hsync,
   output logic              vsync,
   output logic              int_n
);

   logic paperFetch;
   logic paperLines;

   ////////////////////////////////////////////////////////////////////////////
   // Pixel and line counters
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         hc <= '0;
         vc <= '0;
      end else if (hc == `LINE_CLOCKS - 1) begin
         hc <= '0;
         // Wrap at end of frame
         if (vc == `FRAME_LINES - 1)
            vc <= '0;
         else
            vc <= vc + 9'd1;
      end else begin
         hc <= hc + 9'd1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Window decode
   ////////////////////////////////////////////////////////////////////////////

   assign paperLines = (vc < `PAPER_LINES);
   // Undelayed paper, where VRAM is read
   assign paperFetch = paperLines && (hc < `PAPER_WIDTH);

   // Paper as displayed, FETCH_OFFSET clocks later
   assign videoEnable = paperLines && (hc >= `FETCH_OFFSET)
                        && (hc < `PAPER_WIDTH + `FETCH_OFFSET);

   // Load one clock ahead of each 8-pixel group
   assign serializerLoad = paperLines && (hc[2:0] == 3'd7)
                           && (hc >= `FETCH_OFFSET - 1)
                           && (hc < `PAPER_WIDTH + `FETCH_OFFSET - 1);

   // Flash counter step, once per frame
   assign frameTick = (vc == `VSYNC_LINE) && (hc == 9'd0);

   assign blank = ((hc >= `HBLANK_START) && (hc <= `HBLANK_END))
                  || ((vc >= `VBLANK_START) && (vc <= `VBLANK_END));

   // Sync pulses, active low
   assign hsync = !((hc >= `HSYNC_START) && (hc <= `HSYNC_END));
   assign vsync = !((vc >= `VSYNC_LINE) && (vc < `VSYNC_LINE + 4));
   assign int_n = !((vc == `VSYNC_LINE) && (hc < `INT_CLOCKS));

   // Column fetch at hc mod 8 = 1..4, ready before the load at 7
   always_comb begin
      fetchStep = ulaPkg::stepIdle;
      if (paperFetch) begin
         case (hc[2:0])
            3'd1:    fetchStep = ulaPkg::stepBitmapAddr;
            3'd2:    fetchStep = ulaPkg::stepBitmapLoad;
            3'd3:    fetchStep = ulaPkg::stepAttrAddr;
            3'd4:    fetchStep = ulaPkg::stepAttrLoad;
            default: fetchStep = ulaPkg::stepIdle;
         endcase
      end
   end

   // Counter never leaves the line
   assert property (@(posedge clk7) disable iff (!rst_n) hc < `LINE_CLOCKS);

endmodule

// File: hw/pixelBus.sv
`timescale 1ns/10ps

interface pixelBus;

   // Pixel with flash applied, for the standard path
   logic       pixel;
   // Serializer bit without flash, for ULAplus
   logic       rawPixel;
   // Attribute, or border substitute outside the paper
   logic [7:0] attrByte;
   // High in the first clock of a new attrByte
   logic       attrLoad;

   modport fetch (output pixel, output rawPixel, output attrByte, output attrLoad);

   modport stdSide (input pixel, input attrByte);

   modport plusSide (input rawPixel, input attrByte, input attrLoad);

endinterface

// File: hw/ulaPkg.sv
package ulaPkg;

   // Decoded I/O target
   typedef enum logic [1:0] {
      portNone,
      portFe,
      portPlusAddr,
      portPlusData
   } portSelT;

   // Steps of one VRAM fetch, repeated every 8 clocks in the paper
   typedef enum logic [2:0] {
      stepIdle,
      stepBitmapAddr,
      stepBitmapLoad,
      stepAttrAddr,
      stepAttrLoad
   } fetchStepT;

   // 9-bit colour, GGGRRRBBB
   typedef struct packed {
      logic [2:0] g;
      logic [2:0] r;
      logic [2:0] b;
   } rgbT;

   // 16 KB video RAM
   typedef logic [13:0] vramAddrT;

   // Horizontal or vertical counter
   typedef logic [8:0] rasterPosT;

endpackage

// File: hw/ula_config.svh
`ifndef ULA_CONFIG_SVH
`define ULA_CONFIG_SVH

// Raster size in pixel clocks and lines
`define LINE_CLOCKS     448
`define FRAME_LINES     312

// Paper area
`define PAPER_WIDTH     256
`define PAPER_LINES     192

// Clocks from fetch start to displayed pixel
`define FETCH_OFFSET    8

// Sync and interrupt windows, active low at the pins
`define HSYNC_START     344
`define HSYNC_END       375
`define VSYNC_LINE      248
`define INT_CLOCKS      32

// Blanking, ends inclusive
`define HBLANK_START    320
`define HBLANK_END      415
`define VBLANK_START    248
`define VBLANK_END      255

// ULAplus register and data ports
`define PORT_PLUS_ADDR  16'hBF3B
`define PORT_PLUS_DATA  16'hFF3B

`endif
